// File: testbench/cc_testdata.txt
# T name backpressure | W addr data | R addr expected
# P pixel tuser tlast expected_pixel, all values in hex
T identity 0
P 10080300 1 0 10080300
P 3ff00001 0 0 3ff00001
P 0ab556aa 0 1 0ab556aa
T frame_sync 0
W 0 0
W 1 0
W 2 600
W 3 400
W 4 0
W 5 0
W 6 0
W 7 200
W 8 0
W 9 10
W a ffffffe0
W b 0
W c 0
P 10080300 0 0 10080300
P 3ff00001 0 1 3ff00001
P 10080300 1 0 3ff38100
T matrix 0
P 0100140b 0 0 02100003
P 200ffcff 0 1 18f78200
T bypass 0
W c 1
R c 00000001
P 0ab556aa 1 0 0ab556aa
P 0100140b 0 1 0100140b
T backpressure 1
P 12345678 1 0 12345678
P 3abcdef0 0 0 3abcdef0
P 00000000 0 0 00000000
P 3fffffff 0 0 3fffffff
P 25a5a5a5 0 1 25a5a5a5
T regs 0
R 2 00000600
R a ffffffe0
R d 00000004
R e 00000005

// File: filelist.f
source/cc_pkg.sv
source/cc_csr.sv
source/cc_frame_sync.sv
source/cc_stream_stats.sv
source/cc_matrix_pipe.sv
source/color_corrector_top.sv
testbench/tb_color_corrector.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_color_corrector
RTL_TOP   ?= color_corrector_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TB_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_color_corrector.sv
`timescale 1ns/1ps

module tb_color_corrector;

localparam int TIMEOUT = 200; // cycles per wait.

logic        clk_i          = 1'b0;
logic        rst_i;
logic        csr_wr_i;
logic        csr_rd_i;
logic [3:0]  csr_addr_i;
logic [31:0] csr_wdata_i;
logic [31:0] csr_rdata_o;
logic        csr_rvalid_o;
logic        video_i_tvalid;
logic [31:0] video_i_tdata;
logic        video_i_tuser;
logic        video_i_tlast;
logic        video_i_tready;
logic        video_o_tvalid;
logic [31:0] video_o_tdata;
logic        video_o_tuser;
logic        video_o_tlast;
logic        video_o_tready = 1'b1;

logic [33:0]      exp_q [$]; // {tuser, tlast, tdata}.
logic [33:0]      exp_beat;
logic [33:0]      got_beat;
logic [31:0]      rng_state = 32'd84;
logic             bp_on     = 1'b0;
logic [8*16-1:0]  tname     = "none";
logic [8*16-1:0]  next_name;
logic [7:0]       cmd;
logic [31:0]      f0;
logic [31:0]      f1;
logic [31:0]      f2;
logic [31:0]      f3;
int               fd;
int               code;
int               test_errs = 0;
int               passes    = 0;
int               fails     = 0;
bit               in_test   = 0;
bit               done      = 0;

color_corrector_top #(
  .FRACT_WIDTH ( 10 ),
  .CNT_WIDTH   ( 16 )
) dut0 (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .csr_wr_i       ( csr_wr_i       ),
  .csr_rd_i       ( csr_rd_i       ),
  .csr_addr_i     ( csr_addr_i     ),
  .csr_wdata_i    ( csr_wdata_i    ),
  .csr_rdata_o    ( csr_rdata_o    ),
  .csr_rvalid_o   ( csr_rvalid_o   ),
  .video_i_tvalid ( video_i_tvalid ),
  .video_i_tdata  ( video_i_tdata  ),
  .video_i_tuser  ( video_i_tuser  ),
  .video_i_tlast  ( video_i_tlast  ),
  .video_i_tready ( video_i_tready ),
  .video_o_tvalid ( video_o_tvalid ),
  .video_o_tdata  ( video_o_tdata  ),
  .video_o_tuser  ( video_o_tuser  ),
  .video_o_tlast  ( video_o_tlast  ),
  .video_o_tready ( video_o_tready )
);

always #50 clk_i = ~clk_i;

function automatic logic [31:0] xorshift32( input logic [31:0] x );
  logic [31:0] y;
  y = x ^ ( x << 13 );
  y = y ^ ( y >> 17 );
  y = y ^ ( y << 5 );
  return y;
endfunction

task automatic wait_cycle();
  @( posedge clk_i );
  #1;
endtask

// the extra cycle lets a commit reach the frame sync before the next beat.
task automatic reg_write( input logic [3:0] addr, input logic [31:0] data );
  csr_wr_i    = 1'b1;
  csr_addr_i  = addr;
  csr_wdata_i = data;
  wait_cycle();
  csr_wr_i = 1'b0;
  wait_cycle();
endtask

task automatic reg_read( input logic [3:0] addr, input logic [31:0] expected );
  int cnt;
  cnt        = 0;
  csr_rd_i   = 1'b1;
  csr_addr_i = addr;
  wait_cycle();
  csr_rd_i = 1'b0;
  while( !csr_rvalid_o && cnt < TIMEOUT ) begin
    wait_cycle();
    cnt++;
  end
  if( !csr_rvalid_o ) begin
    $display( "%0s: no read response for register %0d", tname, addr );
    test_errs++;
  end else begin
    assert( csr_rdata_o == expected ) else begin
      $display( "error %0s: expected %h actual %h", tname, expected, csr_rdata_o );
      test_errs++;
    end
  end
endtask

task automatic send_pixel( input logic [31:0] pix, input logic tuser, input logic tlast,
                           input logic [31:0] expected );
  int cnt;
  bit acc;
  cnt = 0;
  acc = 0;
  exp_q.push_back( { tuser, tlast, expected } );
  video_i_tvalid = 1'b1;
  video_i_tdata  = pix;
  video_i_tuser  = tuser;
  video_i_tlast  = tlast;
  while( !acc && cnt < TIMEOUT ) begin
    @( negedge clk_i );
    acc = video_i_tready; // ready seen before the accepting edge.
    wait_cycle();
    cnt++;
  end
  video_i_tvalid = 1'b0;
  if( !acc ) begin
    $display( "%0s: input beat %h was never accepted", tname, pix );
    test_errs++;
  end
endtask

task automatic skip_line();
  int ch;
  ch = $fgetc( fd );
  while( ch != 10 && ch != -1 )
    ch = $fgetc( fd );
endtask

task automatic finish_test();
  int cnt;
  cnt = 0;
  while( exp_q.size() > 0 && cnt < TIMEOUT ) begin
    wait_cycle();
    cnt++;
  end
  if( exp_q.size() > 0 ) begin
    $display( "%0s: timed out with %0d output beats missing", tname, exp_q.size() );
    test_errs++;
    exp_q.delete();
  end
  if( test_errs == 0 ) begin
    $display( "test %0s ok", tname );
    passes++;
  end else begin
    $display( "test %0s had %0d errors", tname, test_errs );
    fails++;
  end
endtask

// output ready, random during a back-pressure test.
always @( posedge clk_i ) begin
  #1;
  if( bp_on ) begin
    rng_state      = xorshift32( rng_state );
    video_o_tready = rng_state[0];
  end else begin
    video_o_tready = 1'b1;
  end
end

// compare each output transfer with the oldest expected beat.
always @( negedge clk_i ) begin
  if( !rst_i && video_o_tvalid && video_o_tready ) begin
    assert( exp_q.size() > 0 ) else begin
      $display( "%0s: output beat %h arrived with none expected", tname, video_o_tdata );
      test_errs++;
    end
    if( exp_q.size() > 0 ) begin
      exp_beat = exp_q.pop_front();
      got_beat = { video_o_tuser, video_o_tlast, video_o_tdata };
      assert( got_beat == exp_beat ) else begin
        $display( "error %0s: expected %h actual %h", tname, exp_beat, got_beat );
        test_errs++;
      end
    end
  end
end

initial begin
  rst_i          = 1'b1;
  csr_wr_i       = 1'b0;
  csr_rd_i       = 1'b0;
  csr_addr_i     = 4'd0;
  csr_wdata_i    = 32'd0;
  video_i_tvalid = 1'b0;
  video_i_tdata  = 32'd0;
  video_i_tuser  = 1'b0;
  video_i_tlast  = 1'b0;
  repeat( 3 ) @( posedge clk_i );
  #1;
  rst_i = 1'b0;
  fd = $fopen( "testbench/cc_testdata.txt", "r" );
  if( fd == 0 ) begin
    $display( "could not open the test data file" );
    fails++;
  end else begin
    while( !done ) begin
      code = $fscanf( fd, " %c", cmd );
      if( code != 1 ) begin
        done = 1;
      end else if( cmd == "#" ) begin
        skip_line();
      end else if( cmd == "T" ) begin
        code = $fscanf( fd, " %s %h", next_name, f0 );
        if( in_test )
          finish_test();
        tname     = next_name;
        bp_on     = f0[0];
        test_errs = 0;
        in_test   = 1;
      end else if( cmd == "W" ) begin
        code = $fscanf( fd, " %h %h", f0, f1 );
        reg_write( f0[3:0], f1 );
      end else if( cmd == "R" ) begin
        code = $fscanf( fd, " %h %h", f0, f1 );
        reg_read( f0[3:0], f1 );
      end else if( cmd == "P" ) begin
        code = $fscanf( fd, " %h %h %h %h", f0, f1, f2, f3 );
        send_pixel( f0, f1[0], f2[0], f3 );
      end else begin
        $display( "unknown command in the test data file" );
        test_errs++;
        skip_line();
      end
    end
    if( in_test )
      finish_test();
    $fclose( fd );
  end
  $display( "tests ok %0d, tests with errors %0d", passes, fails );
  if( fails == 0 && passes > 0 )
    $display( "Verification passed" );
  else
    $display( "Verification failed" );
  $finish;
end

endmodule

// File: source/color_corrector_top.sv
`timescale 1ns/1ps

module color_corrector_top #(
  parameter int FRACT_WIDTH = 10,
  parameter int CNT_WIDTH   = 16
)(
  input         clk_i,
  input         rst_i,
  input         csr_wr_i,
  input         csr_rd_i,
  input  [3:0]  csr_addr_i,
  input  [31:0] csr_wdata_i,
  output [31:0] csr_rdata_o,
  output        csr_rvalid_o,
  input         video_i_tvalid,
  input  [31:0] video_i_tdata,
  input         video_i_tuser,
  input         video_i_tlast,
  output        video_i_tready,
  output        video_o_tvalid,
  output [31:0] video_o_tdata,
  output        video_o_tuser,
  output        video_o_tlast,
  input         video_o_tready
);

cc_pkg::cc_cfg_t        shadow;
cc_pkg::cc_cfg_t        active;
logic                   commit;
logic [CNT_WIDTH - 1:0] frames;
logic [CNT_WIDTH - 1:0] line_len;
cc_pkg::rgb_t           in_px;
cc_pkg::rgb_t           out_px;
cc_pkg::side_t          in_side;
cc_pkg::side_t          out_side;
logic                   in_xfer;
logic                   out_xfer;

assign in_px         = cc_pkg::rgb_t'( video_i_tdata[29:0] ); // r in 29..20.
assign in_side.tuser = video_i_tuser;
assign in_side.tlast = video_i_tlast;
assign in_xfer       = video_i_tvalid && video_i_tready;
assign out_xfer      = video_o_tvalid && video_o_tready;
assign video_o_tdata = { 2'b00, out_px };
assign video_o_tuser = out_side.tuser;
assign video_o_tlast = out_side.tlast;

cc_csr #(
  .CNT_WIDTH    ( CNT_WIDTH    )
) cc_csr (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .csr_wr_i     ( csr_wr_i     ),
  .csr_rd_i     ( csr_rd_i     ),
  .csr_addr_i   ( csr_addr_i   ),
  .csr_wdata_i  ( csr_wdata_i  ),
  .frames_i     ( frames       ),
  .line_len_i   ( line_len     ),
  .shadow_o     ( shadow       ),
  .commit_o     ( commit       ),
  .csr_rdata_o  ( csr_rdata_o  ),
  .csr_rvalid_o ( csr_rvalid_o )
);

cc_frame_sync cc_frame_sync (
  .clk_i    ( clk_i         ),
  .rst_i    ( rst_i         ),
  .shadow_i ( shadow        ),
  .commit_i ( commit        ),
  .beat_i   ( in_xfer       ),
  .sof_i    ( video_i_tuser ),
  .active_o ( active        )
);

cc_stream_stats #(
  .CNT_WIDTH  ( CNT_WIDTH )
) cc_stream_stats (
  .clk_i      ( clk_i     ),
  .rst_i      ( rst_i     ),
  .xfer_i     ( out_xfer  ),
  .side_i     ( out_side  ),
  .frames_o   ( frames    ),
  .line_len_o ( line_len  )
);

cc_matrix_pipe #(
  .FRACT_WIDTH ( FRACT_WIDTH    ),
  .side_type   ( cc_pkg::side_t )
) cc_matrix_pipe (
  .clk_i       ( clk_i          ),
  .rst_i       ( rst_i          ),
  .cfg_i       ( active         ),
  .in_valid_i  ( video_i_tvalid ),
  .in_px_i     ( in_px          ),
  .in_side_i   ( in_side        ),
  .in_ready_o  ( video_i_tready ),
  .out_valid_o ( video_o_tvalid ),
  .out_px_o    ( out_px         ),
  .out_side_o  ( out_side       ),
  .out_ready_i ( video_o_tready )
);

endmodule

// File: source/cc_matrix_pipe.sv
`timescale 1ns/1ps

module cc_matrix_pipe #(
  parameter int  FRACT_WIDTH = 10,
  parameter type side_type   = cc_pkg::side_t
)(
  input                   clk_i,
  input                   rst_i,
  input  cc_pkg::cc_cfg_t cfg_i,
  input                   in_valid_i,
  input  cc_pkg::rgb_t    in_px_i,
  input  side_type        in_side_i,
  output logic            in_ready_o,
  output logic            out_valid_o,
  output cc_pkg::rgb_t    out_px_o,
  output side_type        out_side_o,
  input                   out_ready_i
);

localparam int PROD_W = $bits( cc_pkg::coef_t ) + $bits( cc_pkg::px_t ) + 1;
localparam int SUM_W  = PROD_W + 2;
localparam int ROUND  = 1 << ( FRACT_WIDTH - 1 );
localparam int PX_MAX = ( 1 << $bits( cc_pkg::px_t ) ) - 1;

logic                       adv;
cc_pkg::coef_t              coef       [3][3];
cc_pkg::px_t                px_col     [3];
logic                       s1_valid_q;
cc_pkg::rgb_t               s1_px_q;
side_type                   s1_side_q;
logic                       s2_valid_q;
logic signed [PROD_W - 1:0] s2_prod_q  [3][3];
cc_pkg::offs_t              s2_offs_q  [3];
logic                       s2_bypass_q;
cc_pkg::rgb_t               s2_px_q;
side_type                   s2_side_q;
logic                       s3_valid_q;
cc_pkg::rgb_t               s3_px_q;
side_type                   s3_side_q;
cc_pkg::rgb_t               corr_px;

// sum, round, offset and clamp one output channel.
function automatic cc_pkg::px_t calc_chan(
  input logic signed [PROD_W - 1:0] p0,
  input logic signed [PROD_W - 1:0] p1,
  input logic signed [PROD_W - 1:0] p2,
  input cc_pkg::offs_t              offs
);
  logic signed [SUM_W - 1:0] sum;
  logic signed [SUM_W - 1:0] val;
  sum = SUM_W'( p0 ) + SUM_W'( p1 ) + SUM_W'( p2 );
  val = ( sum + SUM_W'( ROUND ) ) >>> FRACT_WIDTH;
  val = val + SUM_W'( offs );
  if( val < 0 )
    return '0;
  else if( val > PX_MAX )
    return cc_pkg::px_t'( PX_MAX );
  else
    return val[$bits( cc_pkg::px_t ) - 1:0];
endfunction

assign adv        = !s3_valid_q || out_ready_i; // single enable for every stage.
assign in_ready_o = adv;

assign coef[0][0] = cfg_i.c00;
assign coef[0][1] = cfg_i.c01;
assign coef[0][2] = cfg_i.c02;
assign coef[1][0] = cfg_i.c10;
assign coef[1][1] = cfg_i.c11;
assign coef[1][2] = cfg_i.c12;
assign coef[2][0] = cfg_i.c20;
assign coef[2][1] = cfg_i.c21;
assign coef[2][2] = cfg_i.c22;

assign px_col[0] = s1_px_q.r;
assign px_col[1] = s1_px_q.g;
assign px_col[2] = s1_px_q.b;

always_ff @( posedge clk_i ) begin
  if( rst_i ) begin
    s1_valid_q <= 1'b0;
    s2_valid_q <= 1'b0;
    s3_valid_q <= 1'b0;
  end else if( adv ) begin
    s1_valid_q <= in_valid_i;
    s2_valid_q <= s1_valid_q;
    s3_valid_q <= s2_valid_q;
  end
end

always_ff @( posedge clk_i ) begin
  if( adv ) begin
    s1_px_q   <= in_px_i;
    s1_side_q <= in_side_i;
    for( int r = 0; r < 3; r++ ) begin
      for( int c = 0; c < 3; c++ )
        s2_prod_q[r][c] <= coef[r][c] * $signed( { 1'b0, px_col[c] } );
    end
    s2_offs_q[0] <= cfg_i.offs_r;
    s2_offs_q[1] <= cfg_i.offs_g;
    s2_offs_q[2] <= cfg_i.offs_b;
    s2_bypass_q  <= cfg_i.bypass; // taken with the products.
    s2_px_q      <= s1_px_q;
    s2_side_q    <= s1_side_q;
    s3_px_q      <= s2_bypass_q ? s2_px_q : corr_px;
    s3_side_q    <= s2_side_q;
  end
end

always_comb begin
  corr_px.r = calc_chan( s2_prod_q[0][0], s2_prod_q[0][1], s2_prod_q[0][2], s2_offs_q[0] );
  corr_px.g = calc_chan( s2_prod_q[1][0], s2_prod_q[1][1], s2_prod_q[1][2], s2_offs_q[1] );
  corr_px.b = calc_chan( s2_prod_q[2][0], s2_prod_q[2][1], s2_prod_q[2][2], s2_offs_q[2] );
end

assign out_valid_o = s3_valid_q;
assign out_px_o    = s3_px_q;
assign out_side_o  = s3_side_q;

endmodule

// File: source/cc_stream_stats.sv
`timescale 1ns/1ps

module cc_stream_stats #(
  parameter int CNT_WIDTH = 16
)(
  input                          clk_i,
  input                          rst_i,
  input                          xfer_i,
  input  cc_pkg::side_t          side_i,
  output logic [CNT_WIDTH - 1:0] frames_o,
  output logic [CNT_WIDTH - 1:0] line_len_o
);

logic [CNT_WIDTH - 1:0] pix_cnt_q;

always_ff @( posedge clk_i ) begin
  if( rst_i ) begin
    pix_cnt_q  <= '0;
    line_len_o <= '0;
    frames_o   <= '0;
  end else if( xfer_i ) begin
    if( side_i.tlast ) begin
      line_len_o <= pix_cnt_q + CNT_WIDTH'( 1 ); // count includes the tlast beat.
      pix_cnt_q  <= '0;
    end else begin
      pix_cnt_q <= pix_cnt_q + CNT_WIDTH'( 1 );
    end
    if( side_i.tuser )
      frames_o <= frames_o + CNT_WIDTH'( 1 );
  end
end

endmodule

// File: source/cc_frame_sync.sv
`timescale 1ns/1ps

module cc_frame_sync (
  input                   clk_i,
  input                   rst_i,
  input  cc_pkg::cc_cfg_t shadow_i,
  input                   commit_i,
  input                   beat_i,
  input                   sof_i,
  output cc_pkg::cc_cfg_t active_o
);

typedef enum logic {
  s_idle,
  s_pending
} state_t;

state_t          state_q;
cc_pkg::cc_cfg_t pending_q;
cc_pkg::cc_cfg_t active_q;
logic            sof_beat;

assign sof_beat = beat_i && sof_i;

always_ff @( posedge clk_i ) begin
  if( rst_i ) begin
    state_q  <= s_idle;
    active_q <= cc_pkg::CFG_IDENTITY;
  end else begin
    case( state_q )
      s_idle: begin
        if( commit_i )
          state_q <= s_pending;
      end
      s_pending: begin
        if( sof_beat ) begin
          active_q <= pending_q;
          // a commit in the same cycle waits for the next frame.
          state_q  <= commit_i ? s_pending : s_idle;
        end
      end
      default: state_q <= s_idle;
    endcase
  end
end

// a later commit simply overwrites the captured copy.
always_ff @( posedge clk_i ) begin
  if( commit_i )
    pending_q <= shadow_i;
end

assign active_o = active_q;

endmodule

// File: source/cc_csr.sv
`timescale 1ns/1ps

module cc_csr #(
  parameter int CNT_WIDTH = 16
)(
  input                          clk_i,
  input                          rst_i,
  input                          csr_wr_i,
  input                          csr_rd_i,
  input        [3:0]             csr_addr_i,
  input        [31:0]            csr_wdata_i,
  input        [CNT_WIDTH - 1:0] frames_i,
  input        [CNT_WIDTH - 1:0] line_len_i,
  output cc_pkg::cc_cfg_t        shadow_o,
  output logic                   commit_o,
  output logic [31:0]            csr_rdata_o,
  output logic                   csr_rvalid_o
);

cc_pkg::cc_cfg_t shadow_q;
logic [31:0]     rd_word;

always_ff @( posedge clk_i ) begin
  if( rst_i ) begin
    shadow_q <= cc_pkg::CFG_IDENTITY;
    commit_o <= 1'b0;
  end else begin
    commit_o <= csr_wr_i && ( csr_addr_i == cc_pkg::REG_CTRL ); // same edge as bypass.
    if( csr_wr_i ) begin
      case( csr_addr_i )
        cc_pkg::REG_COEF_0: shadow_q.c00    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_1: shadow_q.c01    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_2: shadow_q.c02    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_3: shadow_q.c10    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_4: shadow_q.c11    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_5: shadow_q.c12    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_6: shadow_q.c20    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_7: shadow_q.c21    <= csr_wdata_i[15:0];
        cc_pkg::REG_COEF_8: shadow_q.c22    <= csr_wdata_i[15:0];
        cc_pkg::REG_OFFS_R: shadow_q.offs_r <= csr_wdata_i[11:0];
        cc_pkg::REG_OFFS_G: shadow_q.offs_g <= csr_wdata_i[11:0];
        cc_pkg::REG_OFFS_B: shadow_q.offs_b <= csr_wdata_i[11:0];
        cc_pkg::REG_CTRL:   shadow_q.bypass <= csr_wdata_i[0];
        default: ;
      endcase
    end
  end
end

// signed fields are sign extended, counters zero extended.
always_comb begin
  case( csr_addr_i )
    cc_pkg::REG_COEF_0:   rd_word = 32'( shadow_q.c00 );
    cc_pkg::REG_COEF_1:   rd_word = 32'( shadow_q.c01 );
    cc_pkg::REG_COEF_2:   rd_word = 32'( shadow_q.c02 );
    cc_pkg::REG_COEF_3:   rd_word = 32'( shadow_q.c10 );
    cc_pkg::REG_COEF_4:   rd_word = 32'( shadow_q.c11 );
    cc_pkg::REG_COEF_5:   rd_word = 32'( shadow_q.c12 );
    cc_pkg::REG_COEF_6:   rd_word = 32'( shadow_q.c20 );
    cc_pkg::REG_COEF_7:   rd_word = 32'( shadow_q.c21 );
    cc_pkg::REG_COEF_8:   rd_word = 32'( shadow_q.c22 );
    cc_pkg::REG_OFFS_R:   rd_word = 32'( shadow_q.offs_r );
    cc_pkg::REG_OFFS_G:   rd_word = 32'( shadow_q.offs_g );
    cc_pkg::REG_OFFS_B:   rd_word = 32'( shadow_q.offs_b );
    cc_pkg::REG_CTRL:     rd_word = 32'( shadow_q.bypass );
    cc_pkg::REG_FRAMES:   rd_word = 32'( frames_i );
    cc_pkg::REG_LINE_LEN: rd_word = 32'( line_len_i );
    default:              rd_word = 32'd0;
  endcase
end

always_ff @( posedge clk_i ) begin
  if( rst_i )
    csr_rvalid_o <= 1'b0;
  else
    csr_rvalid_o <= csr_rd_i;
end

always_ff @( posedge clk_i ) begin
  if( csr_rd_i )
    csr_rdata_o <= rd_word;
end

assign shadow_o = shadow_q;

endmodule

// File: source/cc_pkg.sv
package cc_pkg;

  typedef logic [9:0] px_t; // one colour channel.

  typedef struct packed {
    px_t r;
    px_t g;
    px_t b;
  } rgb_t;

  typedef logic signed [15:0] coef_t; // q5.10.
  typedef logic signed [11:0] offs_t;

  // row index is the output channel.
  typedef struct packed {
    coef_t c00;
    coef_t c01;
    coef_t c02;
    coef_t c10;
    coef_t c11;
    coef_t c12;
    coef_t c20;
    coef_t c21;
    coef_t c22;
    offs_t offs_r;
    offs_t offs_g;
    offs_t offs_b;
    logic  bypass;
  } cc_cfg_t;

  typedef struct packed {
    logic tuser; // start of frame.
    logic tlast; // end of line.
  } side_t;

  localparam logic [3:0] REG_COEF_0   = 4'd0;
  localparam logic [3:0] REG_COEF_1   = 4'd1;
  localparam logic [3:0] REG_COEF_2   = 4'd2;
  localparam logic [3:0] REG_COEF_3   = 4'd3;
  localparam logic [3:0] REG_COEF_4   = 4'd4;
  localparam logic [3:0] REG_COEF_5   = 4'd5;
  localparam logic [3:0] REG_COEF_6   = 4'd6;
  localparam logic [3:0] REG_COEF_7   = 4'd7;
  localparam logic [3:0] REG_COEF_8   = 4'd8;
  localparam logic [3:0] REG_OFFS_R   = 4'd9;
  localparam logic [3:0] REG_OFFS_G   = 4'd10;
  localparam logic [3:0] REG_OFFS_B   = 4'd11;
  localparam logic [3:0] REG_CTRL     = 4'd12;
  localparam logic [3:0] REG_FRAMES   = 4'd13;
  localparam logic [3:0] REG_LINE_LEN = 4'd14;

  localparam cc_cfg_t CFG_IDENTITY = '{
    c00: 16'sd1024, c01: 16'sd0, c02: 16'sd0,
    c10: 16'sd0, c11: 16'sd1024, c12: 16'sd0,
    c20: 16'sd0, c21: 16'sd0, c22: 16'sd1024,
    offs_r: 12'sd0, offs_g: 12'sd0, offs_b: 12'sd0,
    bypass: 1'b0
  };

endpackage
